//--- include/tele_cfg.svh
`ifndef TELE_CFG_SVH
`define TELE_CFG_SVH

// Telemetry buffer settings

// Records held between dumps
`define TELE_DEPTH 16

// Cycle stamp width, saturates at all-ones
`define TELE_TS_BITS 12

// UART timing in clock cycles per bit
`define TELE_BIT_CYCLES 8

`endif

//--- source/tele_pkg.sv
`include "tele_cfg.svh"

package tele_pkg;

  // Controller state bundle, sampled every cycle
  typedef struct packed {
    logic [4:0] fsm_state;
    logic [4:0] fsm_snext;
    logic [2:0] ddl_state;
    logic       cfg_rst_n;
    logic       cfg_run;
    logic       cfg_req;
    logic       cfg_ref;
    logic [2:0] cfg_cmd;
  } tele_snap_t;

  // One buffered record; stamp and snap give the 32-bit printed word
  typedef struct packed {
    logic                     eod;
    logic [`TELE_TS_BITS-1:0] stamp;
    tele_snap_t               snap;
  } tele_rec_t;

  // ASCII character beat towards the UART
  typedef struct packed {
    logic [7:0] data;
    logic       last;
  } tele_byte_t;

endpackage

//--- source/state_capture.sv
`timescale 1ns/100ps
`include "tele_cfg.svh"

module state_capture
  import tele_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  tele_snap_t state_i,
  input  logic       dump_req_i,
  output logic       rec_valid_o,
  input  logic       rec_ready_i,
  output tele_rec_t  rec_o
);

  localparam int DEPTH = `TELE_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  tele_snap_t               last_q;
  logic [`TELE_TS_BITS-1:0] stamp_q;
  tele_rec_t                mem [DEPTH];
  logic [PTR_W-1:0]         rd_ptr_q;
  logic [PTR_W-1:0]         wr_ptr_q;
  logic [CNT_W-1:0]         count_q;
  logic                     eod_sent_q;

  logic full_w;
  logic empty_w;
  logic wr_en_w;
  logic rd_en_w;
  logic eod_fire_w;

  // Circular pointer step
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    if (ptr == PTR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_w  = (count_q == CNT_W'(DEPTH));
  assign empty_w = (count_q == '0);

  // Capture only while no dump is requested
  assign wr_en_w = !dump_req_i && !full_w && (state_i != last_q);

  assign rec_valid_o = dump_req_i && !eod_sent_q;
  assign rd_en_w     = rec_valid_o && rec_ready_i && !empty_w;
  assign eod_fire_w  = rec_valid_o && rec_ready_i && empty_w;

  // Head record, or the end-of-dump marker once drained
  always_comb begin
    rec_o     = mem[rd_ptr_q];
    rec_o.eod = empty_w;
    if (empty_w) begin
      rec_o.stamp = '0;
      rec_o.snap  = '0;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en_w) begin
      mem[wr_ptr_q] <= '{eod: 1'b0, stamp: stamp_q, snap: state_i};
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      last_q     <= '0;
      stamp_q    <= '0;
      rd_ptr_q   <= '0;
      wr_ptr_q   <= '0;
      count_q    <= '0;
      eod_sent_q <= 1'b0;
    end else begin
      // Cycles since the last recorded change
      if (wr_en_w) begin
        stamp_q <= '0;
      end else if (stamp_q != '1) begin
        stamp_q <= stamp_q + 1'b1;
      end

      if (wr_en_w) begin
        last_q   <= state_i;
        wr_ptr_q <= ptr_inc(wr_ptr_q);
        count_q  <= count_q + 1'b1;
      end else if (rd_en_w) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
        count_q  <= count_q - 1'b1;
      end

      // One marker per request, re-armed when req drops
      if (!dump_req_i) begin
        eod_sent_q <= 1'b0;
      end else if (eod_fire_w) begin
        eod_sent_q <= 1'b1;
      end
    end
  end

  // A full buffer changes only by draining
  a_no_write_full: assert property (@(posedge clock) disable iff (!arst_n)
    full_w && !rd_en_w |=> $stable(wr_ptr_q) && full_w);

  // Offered record holds until it is taken
  a_rec_hold: assert property (@(posedge clock) disable iff (!arst_n)
    rec_valid_o && !rec_ready_i |=> rec_valid_o && $stable(rec_o));

endmodule

//--- source/hex_encoder.sv
`timescale 1ns/100ps

module hex_encoder
  import tele_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  logic       rec_valid_i,
  output logic       rec_ready_o,
  input  tele_rec_t  rec_i,
  output logic       byte_valid_o,
  input  logic       byte_ready_i,
  output tele_byte_t byte_o
);

  localparam logic [3:0] LF_STEP = 4'd8;

  logic        busy_q;
  tele_rec_t   rec_q;
  logic [3:0]  idx_q;
  logic [31:0] word_w;
  logic [3:0]  nib_w;
  logic        byte_fire_w;

  // Nibble to uppercase ASCII hex
  function automatic logic [7:0] hex_char(input logic [3:0] nib);
    if (nib < 4'd10) begin
      return 8'h30 + {4'h0, nib};
    end
    return 8'h37 + {4'h0, nib};
  endfunction

  assign rec_ready_o  = !busy_q;
  assign byte_valid_o = busy_q;
  assign byte_fire_w  = byte_valid_o && byte_ready_i;

  // Stamp then snapshot, most significant nibble first
  assign word_w = {rec_q.stamp, rec_q.snap};
  assign nib_w  = word_w[{3'd7 - idx_q[2:0], 2'b00} +: 4];

  always_comb begin
    byte_o.last = 1'b0;
    if (idx_q == LF_STEP) begin
      byte_o.data = 8'h0a;
      byte_o.last = rec_q.eod;
    end else if (rec_q.eod) begin
      byte_o.data = 8'h2e;
    end else begin
      byte_o.data = hex_char(nib_w);
    end
  end

  always_ff @(posedge clock) begin
    if (rec_valid_i && rec_ready_o) begin
      rec_q <= rec_i;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      busy_q <= 1'b0;
      idx_q  <= '0;
    end else if (!busy_q) begin
      if (rec_valid_i) begin
        busy_q <= 1'b1;
        idx_q  <= '0;
      end
    end else if (byte_fire_w) begin
      if (idx_q == LF_STEP) begin
        busy_q <= 1'b0;
      end else if (rec_q.eod) begin
        // Marker line is just "." then the line feed
        idx_q <= LF_STEP;
      end else begin
        idx_q <= idx_q + 1'b1;
      end
    end
  end

  // Dump ends on a line feed
  a_last_is_lf: assert property (@(posedge clock) disable iff (!arst_n)
    byte_valid_o && byte_o.last |-> byte_o.data == 8'h0a);

endmodule

//--- source/uart_tx.sv
`timescale 1ns/100ps
`include "tele_cfg.svh"

module uart_tx
  import tele_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  logic       byte_valid_i,
  output logic       byte_ready_o,
  input  tele_byte_t byte_i,
  input  logic       dump_req_i,
  output logic       dump_ack_o,
  output logic       uart_tx_o
);

  localparam int BIT_CYC = `TELE_BIT_CYCLES;
  localparam int DIV_W   = (BIT_CYC > 1) ? $clog2(BIT_CYC) : 1;

  logic [DIV_W-1:0] div_q;
  logic [9:0]       frame_q;
  logic [3:0]       bit_q;
  logic             busy_q;
  logic             last_q;
  logic             ack_q;

  logic load_w;
  logic bit_end_w;
  logic frame_end_w;

  assign byte_ready_o = !busy_q;
  assign load_w       = byte_valid_i && !busy_q;
  assign bit_end_w    = busy_q && (div_q == DIV_W'(BIT_CYC - 1));
  assign frame_end_w  = bit_end_w && (bit_q == 4'd9);

  // Line idles on the ones shifted in behind the frame
  assign uart_tx_o  = frame_q[0];
  assign dump_ack_o = ack_q;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      div_q   <= '0;
      frame_q <= '1;
      bit_q   <= '0;
      busy_q  <= 1'b0;
      last_q  <= 1'b0;
      ack_q   <= 1'b0;
    end else begin
      if (load_w) begin
        // Stop, data LSB first, start
        frame_q <= {1'b1, byte_i.data, 1'b0};
        busy_q  <= 1'b1;
        div_q   <= '0;
        bit_q   <= '0;
        last_q  <= byte_i.last;
      end else if (bit_end_w) begin
        frame_q <= {1'b1, frame_q[9:1]};
        div_q   <= '0;
        bit_q   <= bit_q + 1'b1;
        if (frame_end_w) begin
          busy_q <= 1'b0;
          last_q <= 1'b0;
        end
      end else if (busy_q) begin
        div_q <= div_q + 1'b1;
      end

      // Ack once the final stop bit is out, drop after req falls
      if (frame_end_w && last_q) begin
        ack_q <= 1'b1;
      end else if (!dump_req_i) begin
        ack_q <= 1'b0;
      end
    end
  end

  // Four-phase release: ack follows req down within one cycle
  a_ack_release: assert property (@(posedge clock) disable iff (!arst_n)
    !dump_req_i ##1 !dump_req_i |-> !dump_ack_o);

endmodule

//--- source/ddr3_tele_top.sv
`timescale 1ns/100ps

module ddr3_tele_top
  import tele_pkg::*;
(
  input  logic       clock,
  input  logic       arst_n,
  input  tele_snap_t state_i,
  input  logic       dump_req_i,
  output logic       dump_ack_o,
  output logic       uart_tx_o
);

  // Record stream, capture to encoder
  logic       rec_valid;
  logic       rec_ready;
  tele_rec_t  rec;

  // Character stream, encoder to UART
  logic       byte_valid;
  logic       byte_ready;
  tele_byte_t byte_beat;

  state_capture u_capture (
    .clock       (clock),
    .arst_n      (arst_n),
    .state_i     (state_i),
    .dump_req_i  (dump_req_i),
    .rec_valid_o (rec_valid),
    .rec_ready_i (rec_ready),
    .rec_o       (rec)
  );

  hex_encoder u_hex (
    .clock        (clock),
    .arst_n       (arst_n),
    .rec_valid_i  (rec_valid),
    .rec_ready_o  (rec_ready),
    .rec_i        (rec),
    .byte_valid_o (byte_valid),
    .byte_ready_i (byte_ready),
    .byte_o       (byte_beat)
  );

  uart_tx u_uart (
    .clock        (clock),
    .arst_n       (arst_n),
    .byte_valid_i (byte_valid),
    .byte_ready_o (byte_ready),
    .byte_i       (byte_beat),
    .dump_req_i   (dump_req_i),
    .dump_ack_o   (dump_ack_o),
    .uart_tx_o    (uart_tx_o)
  );

endmodule

//--- test/tb_clock.sv
`timescale 1ns/100ps

module tb_clock #(
  parameter int PERIOD_NS    = 8,
  parameter int RESET_CYCLES = 8
) (
  output logic clock_o,
  output logic arst_n_o
);

  initial begin
    clock_o = 1'b0;
    forever #(PERIOD_NS / 2) clock_o = ~clock_o;
  end

  // Release on a falling edge, clear of the sampling edge
  initial begin
    arst_n_o = 1'b0;
    repeat (RESET_CYCLES) @(posedge clock_o);
    @(negedge clock_o);
    arst_n_o = 1'b1;
  end

endmodule

//--- test/tb_ddr3_tele.sv
`timescale 1ns/100ps
`include "tele_cfg.svh"

module tb_ddr3_tele
  import tele_pkg::*;
();

  localparam int DEPTH          = `TELE_DEPTH;
  localparam int BIT_CYC        = `TELE_BIT_CYCLES;
  localparam int NUM_DUMPS      = 6;
  localparam int SAT_IDLE       = (1 << `TELE_TS_BITS) + 100;
  localparam int FILL_CAP       = 400;
  localparam int TAIL_CYC       = 40;
  localparam int HOLD_CYC       = 4;
  localparam int CAPTURE_CYCLES = SAT_IDLE + 4 * FILL_CAP + TAIL_CYC + 200;
  localparam int DUMP_CYCLES    = (DEPTH + 1) * 9 * 10 * BIT_CYC;
  localparam int CYCLE_LIMIT    = NUM_DUMPS * DUMP_CYCLES + CAPTURE_CYCLES + 2000;
  localparam logic [31:0] LFSR_SEED = 32'd69909;
  localparam logic [31:0] LFSR_TAPS = 32'hD000_0001;

  logic       clock;
  logic       arst_n;
  tele_snap_t state;
  logic       dump_req;
  logic       dump_ack;
  logic       uart_line;

  logic [31:0]              lfsr_state;
  int                       cycle_count = 0;
  logic [7:0]               rx_q[$];
  logic [7:0]               rx_byte;
  tele_snap_t               model_last;
  logic [`TELE_TS_BITS-1:0] model_stamp;
  logic [31:0]              model_q[$];

  tb_clock #(
    .PERIOD_NS    (8),
    .RESET_CYCLES (8)
  ) u_clock (
    .clock_o  (clock),
    .arst_n_o (arst_n)
  );

  ddr3_tele_top dut0 (
    .clock      (clock),
    .arst_n     (arst_n),
    .state_i    (state),
    .dump_req_i (dump_req),
    .dump_ack_o (dump_ack),
    .uart_tx_o  (uart_line)
  );

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ LFSR_TAPS) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_state[0]};
      lfsr_state = lfsr_next(lfsr_state);
    end
    return v;
  endfunction

  function automatic tele_snap_t rand_snap();
    logic [31:0] v;
    v = rand_bits(20);
    return tele_snap_t'(v[19:0]);
  endfunction

  // Uppercase ASCII digit for one nibble
  function automatic logic [7:0] hex_ascii(input logic [3:0] nib);
    if (nib < 4'd10) begin
      return 8'h30 + {4'h0, nib};
    end
    return 8'h41 + {4'h0, nib} - 8'd10;
  endfunction

  task automatic stop_on_error();
    $display("TB FAILED");
    $fatal(1, "stopping at first error");
  endtask

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("mismatch %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
      stop_on_error();
    end
  endtask

  // Capture rule applied on the same edges as the DUT
  always @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      model_last  = '0;
      model_stamp = '0;
      model_q.delete();
    end else if (!dump_req && model_q.size() < DEPTH && state != model_last) begin
      model_q.push_back({model_stamp, state});
      model_last  = state;
      model_stamp = '0;
    end else if (model_stamp != '1) begin
      model_stamp = model_stamp + 1'b1;
    end
  end

  // UART receiver sampling mid-bit on falling edges
  always begin
    @(negedge clock);
    if (arst_n === 1'b1 && uart_line === 1'b0) begin
      repeat (BIT_CYC / 2 - 1) @(negedge clock);
      if (uart_line !== 1'b0) begin
        $display("UART start bit did not hold until mid-bit");
        stop_on_error();
      end
      for (int i = 0; i < 8; i++) begin
        repeat (BIT_CYC) @(negedge clock);
        rx_byte[i] = uart_line;
      end
      repeat (BIT_CYC) @(negedge clock);
      if (uart_line !== 1'b1) begin
        $display("UART stop bit was low");
        stop_on_error();
      end
      rx_q.push_back(rx_byte);
    end
  end

  always @(posedge clock) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
      stop_on_error();
    end
  end

  task automatic idle(input int cycles);
    repeat (cycles) @(negedge clock);
  endtask

  // Change the state with odds of one in 2**odds_bits
  task automatic step_state(input int odds_bits);
    @(negedge clock);
    if (rand_bits(odds_bits) == '0) begin
      state = rand_snap();
    end
  endtask

  task automatic fill_records(input int target);
    int steps;
    steps = 0;
    while (model_q.size() < target && steps < FILL_CAP) begin
      step_state(2);
      steps++;
    end
  endtask

  task automatic run_dump(input string name, input bit churn);
    logic [7:0] exp_q[$];
    tele_snap_t held;
    int         pos;
    bit         done;
    @(negedge clock);
    check({name, " ack idle"}, 32'd0, 32'(dump_ack));
    check({name, " line idle"}, 32'd1, 32'(uart_line));
    check({name, " stray chars"}, 32'd0, rx_q.size());
    foreach (model_q[r]) begin
      for (int n = 7; n >= 0; n--) begin
        exp_q.push_back(hex_ascii(model_q[r][n * 4 +: 4]));
      end
      exp_q.push_back(8'h0a);
    end
    exp_q.push_back(8'h2e);
    exp_q.push_back(8'h0a);
    // Whole buffer goes out and the model starts empty
    model_q.delete();
    held     = state;
    dump_req = 1'b1;
    pos      = 0;
    done     = 1'b0;
    while (!done) begin
      @(negedge clock);
      while (rx_q.size() > 0) begin
        if (exp_q.size() == 0) begin
          $display("%s: a character arrived after the end of the dump", name);
          stop_on_error();
        end
        check($sformatf("%s char %0d", name, pos), 32'(exp_q.pop_front()),
              32'(rx_q.pop_front()));
        pos++;
      end
      if (dump_ack === 1'b1) begin
        check({name, " chars left at ack"}, 32'd0, exp_q.size());
        done = 1'b1;
      end else if (churn && rand_bits(1) == '0) begin
        state = rand_snap();
      end
    end
    repeat (HOLD_CYC) begin
      @(negedge clock);
      check({name, " ack held"}, 32'd1, 32'(dump_ack));
    end
    // Back to the recorded value so the churn leaves no trace
    state    = held;
    dump_req = 1'b0;
    @(negedge clock);
    check({name, " ack release"}, 32'd0, 32'(dump_ack));
  endtask

  initial begin
    lfsr_state = LFSR_SEED;
    state      = '0;
    dump_req   = 1'b0;
    @(posedge arst_n);
    @(negedge clock);
    check("reset line", 32'd1, 32'(uart_line));
    check("reset ack", 32'd0, 32'(dump_ack));

    // Nothing captured yet
    run_dump("empty dump", 1'b0);

    // First stamp saturates after the long idle
    idle(SAT_IDLE);
    fill_records(10);
    idle(4);
    run_dump("random dump", 1'b0);

    // Changes under req stay out of the buffer
    fill_records(5);
    idle(4);
    run_dump("churn dump", 1'b1);
    idle(4);
    run_dump("post churn dump", 1'b0);

    // Overflow keeps the oldest records
    fill_records(DEPTH);
    repeat (TAIL_CYC) step_state(1);
    check("overflow fill", DEPTH, model_q.size());
    run_dump("overflow dump", 1'b0);

    fill_records(3);
    idle(4);
    run_dump("second request", 1'b0);

    $display("TB PASSED");
    $finish;
  end

endmodule

//--- compile.f
+incdir+include
source/tele_pkg.sv
source/state_capture.sv
source/hex_encoder.sv
source/uart_tx.sv
source/ddr3_tele_top.sv
test/tb_clock.sv
test/tb_ddr3_tele.sv

//--- Makefile
# Verilator build and run of the telemetry testbench

VERILATOR ?= verilator
TOP       ?= tb_ddr3_tele
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert --timescale 1ns/100ps
PASS_TEXT ?= TB PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
